/* sqrt_config.svh */
// Build-time sizes for the matrix square-root accelerator
// Include wherever a width or the lane count is needed
// Types built on these widths are in the shared package

`ifndef SQRT_CONFIG_SVH
`define SQRT_CONFIG_SVH

// Even element width so the root is exactly half
`define SQRT_DATA_SIZE 32

// Row and column index and size width
`define SQRT_CONTROL_SIZE 8

// At least two parallel scalar lanes
`define SQRT_LANES 4

`endif

/* sqrt_pkg.sv */
// Shared types and constants for the matrix square-root accelerator
// Import inside module bodies, use scoped names in port lists

`default_nettype none

`include "sqrt_config.svh"

package sqrt_pkg;

  // Iteration cycles per root, one result bit per cycle
  localparam int SQRT_LATENCY = `SQRT_DATA_SIZE / 2;

  typedef logic [`SQRT_DATA_SIZE-1:0]    data_t;
  typedef logic [`SQRT_DATA_SIZE/2-1:0]  root_t;
  typedef logic [`SQRT_CONTROL_SIZE-1:0] index_t;
  typedef logic [$clog2(`SQRT_LANES)-1:0] lane_t;

  // Position flags riding along with each element
  typedef struct packed {
    logic row_first;
    logic matrix_last;
  } elem_tag_t;

endpackage

`default_nettype wire

/* sqrt_lane_if.sv */
// Issue and completion signals of one scalar square-root lane
// Dispatcher issues, lane computes, collector drains the result

`timescale 1ns/1ps
`default_nettype none

interface sqrt_lane_if;
  import sqrt_pkg::*;

  // Issue side driven by the dispatcher
  logic      issue;
  data_t     operand;
  elem_tag_t issue_tag;

  // Completion side driven by the lane
  logic      busy;
  logic      done;
  root_t     root;
  elem_tag_t done_tag;

  // Issue only while busy is low
  modport dispatcher (output issue, operand, issue_tag, input busy);

  modport lane (
    input  issue, operand, issue_tag,
    output busy, done, root, done_tag
  );

  // Collector only watches the completion side
  modport collector (input done, root, done_tag);

endinterface

`default_nettype wire

/* scalar_sqrt_unit.sv */
// Fixed-latency integer square root of one unsigned element
// Restoring digit-by-digit method, two operand bits per cycle
// done pulses SQRT_LATENCY+1 cycles after issue, tag returned with root

`timescale 1ns/1ps
`default_nettype none

module scalar_sqrt_unit (
  input wire        CLK,
  input wire        RST,
  sqrt_lane_if.lane lane
);
  import sqrt_pkg::*;

  localparam int CNT_W  = $clog2(SQRT_LATENCY + 1);
  localparam int REM_W  = SQRT_LATENCY + 2;
  localparam int ROOT_W = $bits(root_t);
  localparam int DATA_W = $bits(data_t);

  ////////////////////////////////////////
  // Iteration state
  ////////////////////////////////////////

  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] count_q;

  // Payload loaded at issue
  logic [REM_W-1:0] rem_q;
  root_t            root_q;
  data_t            op_q;
  elem_tag_t        tag_q;

  logic [REM_W-1:0] rem_shift;
  logic [REM_W-1:0] trial;
  logic             fits;

  // Bring down next two operand bits, try root*4+1
  always_comb begin
    rem_shift = {rem_q[REM_W-3:0], op_q[DATA_W-1 -: 2]};
    trial     = {root_q, 2'b01};
    fits      = (rem_shift >= trial);
  end

  // Control holds busy from issue until the last iteration
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      count_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (lane.issue) begin
        busy_q  <= 1'b1;
        count_q <= CNT_W'(SQRT_LATENCY);
      end else if (busy_q) begin
        count_q <= count_q - 1'b1;
        // Final step lands now, done shows next cycle
        if (count_q == CNT_W'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (lane.issue) begin
      rem_q  <= '0;
      root_q <= '0;
      op_q   <= lane.operand;
      tag_q  <= lane.issue_tag;
    end else if (busy_q) begin
      op_q   <= op_q << 2;
      rem_q  <= fits ? (rem_shift - trial) : rem_shift;
      root_q <= {root_q[ROOT_W-2:0], fits};
    end
  end

  assign lane.busy     = busy_q;
  assign lane.done     = done_q;
  assign lane.root     = root_q;
  assign lane.done_tag = tag_q;

  // Dispatcher must respect busy
  issue_when_idle: assert property (@(posedge CLK) disable iff (RST)
    lane.issue |-> !busy_q);

  // Fixed latency the collector ordering relies on
  done_latency: assert property (@(posedge CLK) disable iff (RST)
    lane.issue |-> ##(SQRT_LATENCY + 1) done_q);

endmodule

`default_nettype wire

/* matrix_sqrt_dispatcher.sv */
// Matrix sequencer on the input side of the square-root accelerator
// Counts rows and columns, tags each element, issues round-robin to lanes
// DATA_IN_READY paces the source, next START waits for matrix_done

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_config.svh"

module matrix_sqrt_dispatcher (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 START,
  input  wire sqrt_pkg::index_t SIZE_I_IN,
  input  wire sqrt_pkg::index_t SIZE_J_IN,
  input  wire                 DATA_IN_I_ENABLE,
  input  wire                 DATA_IN_J_ENABLE,
  input  wire sqrt_pkg::data_t  DATA_IN,
  output logic                DATA_IN_READY,
  sqrt_lane_if.dispatcher     lanes [`SQRT_LANES],
  input  wire                 matrix_done
);
  import sqrt_pkg::*;

  typedef enum logic [1:0] {st_idle, st_stream, st_drain} state_t;

  state_t state_q;
  index_t size_i_q;
  index_t size_j_q;
  index_t row_q;
  index_t col_q;
  lane_t  rr_ptr_q;

  // Issue register holding one element on its way to a lane
  logic      issue_q;
  lane_t     issue_lane_q;
  data_t     operand_q;
  elem_tag_t tag_q;

  logic [`SQRT_LANES-1:0] lane_busy;
  logic accept;
  logic row_last;
  logic col_last;

  ////////////////////////////////////////
  // Pacing
  ////////////////////////////////////////

  // Next lane in rotation must be free
  assign DATA_IN_READY = (state_q == st_stream) && !lane_busy[rr_ptr_q];
  assign accept        = (DATA_IN_I_ENABLE || DATA_IN_J_ENABLE) && DATA_IN_READY;
  assign row_last      = (row_q == size_i_q - index_t'(1));
  assign col_last      = (col_q == size_j_q - index_t'(1));

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= st_idle;
      size_i_q     <= '0;
      size_j_q     <= '0;
      row_q        <= '0;
      col_q        <= '0;
      rr_ptr_q     <= '0;
      issue_q      <= 1'b0;
      issue_lane_q <= '0;
    end else begin
      issue_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (START) begin
            size_i_q <= SIZE_I_IN;
            size_j_q <= SIZE_J_IN;
            row_q    <= '0;
            col_q    <= '0;
            state_q  <= st_stream;
          end
        end
        st_stream: begin
          if (accept) begin
            issue_q      <= 1'b1;
            issue_lane_q <= rr_ptr_q;
            rr_ptr_q     <= (rr_ptr_q == lane_t'(`SQRT_LANES - 1)) ? '0 : rr_ptr_q + 1'b1;
            // Row-major stepping
            if (col_last) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
              if (row_last) begin
                state_q <= st_drain;
              end
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        st_drain: begin
          // Hold off START until READY leaves the collector
          if (matrix_done) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Element payload and its tag
  always_ff @(posedge CLK) begin
    if (accept) begin
      operand_q         <= DATA_IN;
      tag_q.row_first   <= (col_q == '0);
      tag_q.matrix_last <= row_last && col_last;
    end
  end

  ////////////////////////////////////////
  // Lane fan-out
  ////////////////////////////////////////

  for (genvar g = 0; g < `SQRT_LANES; g++) begin : g_issue
    assign lanes[g].issue     = issue_q && (issue_lane_q == lane_t'(g));
    assign lanes[g].operand   = operand_q;
    assign lanes[g].issue_tag = tag_q;
    assign lane_busy[g]       = lanes[g].busy;
  end

  // Source must wait for DATA_IN_READY
  enable_when_ready: assert property (@(posedge CLK) disable iff (RST)
    (DATA_IN_I_ENABLE || DATA_IN_J_ENABLE) |-> DATA_IN_READY);

  // I strobe on column 0 only, J strobe elsewhere
  strobe_matches_col: assert property (@(posedge CLK) disable iff (RST)
    accept |-> (DATA_IN_I_ENABLE == (col_q == '0)) && (DATA_IN_J_ENABLE != (col_q == '0)));

endmodule

`default_nettype wire

/* matrix_sqrt_collector.sv */
// Output side of the matrix square-root accelerator
// Drains lane results in issue order onto DATA_OUT and the strobes
// READY comes with the result tagged as the last of the matrix

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_config.svh"

module matrix_sqrt_collector (
  input  wire              CLK,
  input  wire              RST,
  sqrt_lane_if.collector   lanes [`SQRT_LANES],
  output sqrt_pkg::root_t  DATA_OUT,
  output logic             DATA_OUT_I_ENABLE,
  output logic             DATA_OUT_J_ENABLE,
  output logic             READY
);
  import sqrt_pkg::*;

  ////////////////////////////////////////
  // Lane gather
  ////////////////////////////////////////

  logic [`SQRT_LANES-1:0] lane_done;
  root_t                  lane_root [`SQRT_LANES];
  elem_tag_t              lane_tag  [`SQRT_LANES];

  for (genvar g = 0; g < `SQRT_LANES; g++) begin : g_gather
    assign lane_done[g] = lanes[g].done;
    assign lane_root[g] = lanes[g].root;
    assign lane_tag[g]  = lanes[g].done_tag;
  end

  // Drain pointer follows the dispatcher rotation
  lane_t                  rd_ptr_q;
  logic                   take;
  elem_tag_t              sel_tag;
  logic [`SQRT_LANES-1:0] expect_mask;

  assign take        = lane_done[rd_ptr_q];
  assign sel_tag     = lane_tag[rd_ptr_q];
  assign expect_mask = `SQRT_LANES'(1) << rd_ptr_q;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_ptr_q          <= '0;
      DATA_OUT          <= '0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      // Strobes are single-cycle
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      READY             <= 1'b0;
      if (take) begin
        DATA_OUT          <= lane_root[rd_ptr_q];
        DATA_OUT_J_ENABLE <= 1'b1;
        DATA_OUT_I_ENABLE <= sel_tag.row_first;
        READY             <= sel_tag.matrix_last;
        rd_ptr_q          <= (rd_ptr_q == lane_t'(`SQRT_LANES - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Fixed lane latency keeps completions in issue order
  in_order_done: assert property (@(posedge CLK) disable iff (RST)
    (lane_done & ~expect_mask) == '0);

endmodule

`default_nettype wire

/* matrix_sqrt_function.sv */
// Top level of the streaming matrix square-root accelerator
// Dispatcher feeds a ring of scalar lanes, collector restores order
// Plain ports outside, one lane interface per lane inside

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_config.svh"

module matrix_sqrt_function (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   START,
  input  wire sqrt_pkg::index_t SIZE_I_IN,
  input  wire sqrt_pkg::index_t SIZE_J_IN,
  input  wire                   DATA_IN_I_ENABLE,
  input  wire                   DATA_IN_J_ENABLE,
  input  wire sqrt_pkg::data_t  DATA_IN,
  output logic                  DATA_IN_READY,
  output logic                  DATA_OUT_I_ENABLE,
  output logic                  DATA_OUT_J_ENABLE,
  output sqrt_pkg::root_t       DATA_OUT,
  output logic                  READY
);

  sqrt_lane_if lane_bus [`SQRT_LANES] ();

  // READY loops back so the next START waits for the drain
  matrix_sqrt_dispatcher matrix_sqrt_dispatcher_inst (
    .CLK, .RST, .START, .SIZE_I_IN, .SIZE_J_IN,
    .DATA_IN_I_ENABLE, .DATA_IN_J_ENABLE, .DATA_IN, .DATA_IN_READY,
    .lanes(lane_bus), .matrix_done(READY)
  );

  // Scalar lanes
  for (genvar g = 0; g < `SQRT_LANES; g++) begin : g_lane
    scalar_sqrt_unit scalar_sqrt_unit_inst (.CLK, .RST, .lane(lane_bus[g]));
  end

  matrix_sqrt_collector matrix_sqrt_collector_inst (
    .CLK, .RST, .lanes(lane_bus),
    .DATA_OUT, .DATA_OUT_I_ENABLE, .DATA_OUT_J_ENABLE, .READY
  );

endmodule

`default_nettype wire

/* matrix_sqrt_tb.sv */
// Self-checking testbench for the matrix square-root accelerator
// Streams the matrices from matrix_sqrt_input.txt through the DUT
// Monitor checks each root, its strobes and its fixed latency

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_config.svh"

module matrix_sqrt_tb;
  import sqrt_pkg::*;

  logic   CLK;
  logic   RST;
  logic   START;
  index_t SIZE_I_IN;
  index_t SIZE_J_IN;
  logic   DATA_IN_I_ENABLE;
  logic   DATA_IN_J_ENABLE;
  data_t  DATA_IN;
  logic   DATA_IN_READY;
  logic   DATA_OUT_I_ENABLE;
  logic   DATA_OUT_J_ENABLE;
  root_t  DATA_OUT;
  logic   READY;

  // Test table and element lists from the data file
  string  test_name_q [$];
  index_t test_si_q [$];
  index_t test_sj_q [$];
  int     test_len_q [$];
  data_t  elem_data_q [$];
  root_t  elem_root_q [$];
  int     elem_gap_q [$];

  // Results still expected with the oldest at the front
  root_t  exp_root_q [$];
  logic   exp_first_q [$];
  logic   exp_last_q [$];
  int     exp_cycle_q [$];

  int     errors = 0;
  int     test_errors = 0;
  int     results_seen = 0;
  int     results_total = 0;
  int     cycle = 0;
  logic   matrix_seen = 1'b0;
  logic   load_done = 1'b0;
  integer seed = 32'hea0c;

  matrix_sqrt_function matrix_sqrt_function_inst (
    .CLK, .RST, .START, .SIZE_I_IN, .SIZE_J_IN,
    .DATA_IN_I_ENABLE, .DATA_IN_J_ENABLE, .DATA_IN, .DATA_IN_READY,
    .DATA_OUT_I_ENABLE, .DATA_OUT_J_ENABLE, .DATA_OUT, .READY
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic record_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_root(input root_t got, input root_t exp);
    if (got !== exp) begin
      $display("ERROR DATA_OUT: got 0x%h, expected 0x%h", got, exp);
      record_error();
    end
  endtask

  task automatic check_flags(input logic got_i, input logic got_ready,
                             input logic exp_i, input logic exp_ready);
    if (got_i !== exp_i) begin
      $display("ERROR DATA_OUT_I_ENABLE: got 0x%h, expected 0x%h", got_i, exp_i);
      record_error();
    end
    if (got_ready !== exp_ready) begin
      $display("ERROR READY: got 0x%h, expected 0x%h", got_ready, exp_ready);
      record_error();
    end
  endtask

  task automatic check_count(input index_t got, input index_t exp);
    if (got !== exp) begin
      $display("ERROR result count: got 0x%h, expected 0x%h", got, exp);
      record_error();
    end
  endtask

  task automatic compare_ready_level(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR DATA_IN_READY: got 0x%h, expected 0x%h", got, exp);
      record_error();
    end
  endtask

  // Root is registered L+2 edges after the enable edge and seen one edge later
  task automatic check_latency(input int seen);
    if (seen != SQRT_LATENCY + 3) begin
      $display("Result took %0d cycles after its enable instead of %0d",
               seen - 1, SQRT_LATENCY + 2);
      record_error();
    end
  endtask

  ////////////////////////////////////////
  // Data file
  ////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string word;
    string name;
    int    si;
    int    sj;
    data_t d;
    root_t r;
    int    g;
    fd = $fopen("matrix_sqrt_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file matrix_sqrt_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n <= 0 || line[0] == "#") continue;
      n = $sscanf(line, "%s", word);
      if (n != 1) continue;
      if (word == "test") begin
        n = $sscanf(line, "%s %s %d %d", word, name, si, sj);
        test_name_q.push_back(name);
        test_si_q.push_back(index_t'(si));
        test_sj_q.push_back(index_t'(sj));
        test_len_q.push_back(0);
      end else if (test_len_q.size() > 0) begin
        n = $sscanf(line, "%h %h %d", d, r, g);
        elem_data_q.push_back(d);
        elem_root_q.push_back(r);
        elem_gap_q.push_back(g);
        test_len_q[test_len_q.size() - 1] += 1;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Stimulus on the falling edge
  ////////////////////////////////////////

  task automatic drive_idle();
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
  endtask

  task automatic run_test(input int t, inout int base);
    int   n;
    int   k;
    int   gap_now;
    int   limit;
    logic first;
    n            = test_len_q[t];
    test_errors  = 0;
    results_seen = 0;
    matrix_seen  = 1'b0;
    if (n != int'(test_si_q[t]) * int'(test_sj_q[t])) begin
      $display("Test %s lists %0d elements but its sizes need %0d", test_name_q[t], n,
               int'(test_si_q[t]) * int'(test_sj_q[t]));
      record_error();
    end
    // No matrix open yet
    @(negedge CLK);
    compare_ready_level(DATA_IN_READY, 1'b0);
    // One-cycle START with the sizes
    START     = 1'b1;
    SIZE_I_IN = test_si_q[t];
    SIZE_J_IN = test_sj_q[t];
    for (k = 0; k < n; k++) begin
      @(negedge CLK);
      drive_idle();
      gap_now = (elem_gap_q[base + k] == 0) ? 0 :
                $unsigned($random(seed)) % (elem_gap_q[base + k] + 1);
      repeat (gap_now) @(negedge CLK);
      // All lanes drained before this matrix opened
      if (k == 0) compare_ready_level(DATA_IN_READY, 1'b1);
      while (DATA_IN_READY !== 1'b1) @(negedge CLK);
      // I strobe on column 0, J strobe elsewhere
      first            = (k % test_sj_q[t]) == 0;
      DATA_IN          = elem_data_q[base + k];
      DATA_IN_I_ENABLE = first;
      DATA_IN_J_ENABLE = !first;
      exp_root_q.push_back(elem_root_q[base + k]);
      exp_first_q.push_back(first);
      exp_last_q.push_back(k == n - 1);
      exp_cycle_q.push_back(cycle + 1);
    end
    @(negedge CLK);
    drive_idle();
    // No elements remain after the last one
    compare_ready_level(DATA_IN_READY, 1'b0);
    // Bounded wait for READY
    limit = n * (SQRT_LATENCY + `SQRT_LANES + 8) + 50;
    while (!matrix_seen && limit > 0) begin
      @(negedge CLK);
      limit--;
    end
    if (!matrix_seen) begin
      $display("Test %s: READY never arrived, %0d results still missing",
               test_name_q[t], exp_root_q.size());
      record_error();
    end
    check_count(index_t'(results_seen), index_t'(n));
    exp_root_q.delete();
    exp_first_q.delete();
    exp_last_q.delete();
    exp_cycle_q.delete();
    results_total += results_seen;
    $display("Test %-6s %0dx%0d: %0d results, %0d errors", test_name_q[t],
             test_si_q[t], test_sj_q[t], results_seen, test_errors);
    base += n;
  endtask

  ////////////////////////////////////////
  // Output monitor on the rising edge
  ////////////////////////////////////////

  always @(posedge CLK) begin
    cycle++;
    if (DATA_OUT_J_ENABLE === 1'b1) begin
      results_seen++;
      if (exp_root_q.size() == 0) begin
        $display("Result 0x%h arrived with no element outstanding", DATA_OUT);
        record_error();
      end else begin
        check_root(DATA_OUT, exp_root_q.pop_front());
        check_flags(DATA_OUT_I_ENABLE, READY, exp_first_q.pop_front(),
                    exp_last_q.pop_front());
        check_latency(cycle - exp_cycle_q.pop_front());
      end
      if (READY === 1'b1) matrix_seen = 1'b1;
    end else if (!RST && (DATA_OUT_I_ENABLE !== 1'b0 || READY !== 1'b0)) begin
      $display("Row or end strobe came without DATA_OUT_J_ENABLE");
      record_error();
    end
  end

  // Watchdog sized from the element count
  initial begin
    int limit;
    wait (load_done);
    limit = elem_data_q.size() * (SQRT_LATENCY + `SQRT_LANES + 8)
            + 100 * (test_name_q.size() + 1);
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run is stuck", limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int t;
    int base;
    base = 0;
    RST       = 1'b1;
    SIZE_I_IN = '0;
    SIZE_J_IN = '0;
    DATA_IN   = '0;
    drive_idle();
    load_tests();
    load_done = 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    for (t = 0; t < test_name_q.size(); t++) begin
      run_test(t, base);
    end
    $display("Tests %0d, results %0d, errors %0d", test_name_q.size(), results_total,
             errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* matrix_sqrt_input.txt */
# test <name> <rows> <cols>, then one line per element in row order
# <element hex> <expected root hex> <max random idle cycles before it>
test roots 2 3
00000000 0000 0
00000001 0001 0
0000000f 0003 0
00000010 0004 0
ffffffff ffff 0
3b9aca00 7b86 0
test gaps 2 3
00000002 0001 3
00000063 0009 3
00010000 0100 3
00000064 000a 3
fffe0001 ffff 3
fffe0000 fffe 3
test one 1 1
00000019 0005 0
test row 1 4
00000003 0001 1
00000008 0002 1
00000009 0003 1
00989680 0c5a 1
test col 3 1
00000024 0006 2
00000030 0006 2
7fffffff b504 2

/* vlog.f */
+incdir+.
sqrt_pkg.sv
sqrt_lane_if.sv
scalar_sqrt_unit.sv
matrix_sqrt_dispatcher.sv
matrix_sqrt_collector.sv
matrix_sqrt_function.sv
matrix_sqrt_tb.sv

/* Bender.yml */
package:
  name: matrix_sqrt

sources:
  - include_dirs:
      - .
    files:
      - sqrt_pkg.sv
      - sqrt_lane_if.sv
      - scalar_sqrt_unit.sv
      - matrix_sqrt_dispatcher.sv
      - matrix_sqrt_collector.sv
      - matrix_sqrt_function.sv
  - target: test
    include_dirs:
      - .
    files:
      - matrix_sqrt_tb.sv
